//--- car_dispatch.sv
////////////////////
// Car dispatch
// Target, direction, arrival pop, flush and door permits
////////////////////

`timescale 1ns/100ps
`default_nettype none

module car_dispatch
    import elevator_pkg::*;
(
    input  wire         clock,
    input  wire         reset_n,
    input  wire         door_open_btn,
    input  wire         door_close_btn,
    input  wire         emergency_btn,
    input  wire         power_switch,
    input  floor_t      current_floor_state,
    input  state_t      elevator_state,
    request_if.dispatch req,
    output floor_t      elevator_floor_selector,
    output logic        direction_selector,
    output logic        activate_elevator,
    output logic        door_open_allowed,
    output logic        door_close_allowed
);

    logic stopped;
    logic service;
    logic at_head;
    logic go_up;
    logic dir_q;

    assign stopped = is_stop_state(elevator_state);

    // Power loss or emergency drops every pending request
    assign req.flush = !power_switch || emergency_btn;

    // Only a stopped, powered car takes a new target
    assign service = power_switch && !emergency_btn && stopped && !req.queue_empty;
    assign at_head = (req.head_floor == current_floor_state);
    assign go_up   = (req.head_floor > current_floor_state);

    ////////////////////
    // Target outputs
    ////////////////////

    assign activate_elevator       = service && !at_head;
    // Car already at the oldest request, retire it
    assign req.pop                 = service && at_head;
    assign elevator_floor_selector = activate_elevator ? req.head_floor : current_floor_state;

    // Direction of the last dispatch, kept while idle
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dir_q <= 1'b0;
        end else if (activate_elevator) begin
            dir_q <= go_up;
        end
    end

    // Up is 1, valid in the activation cycle itself
    assign direction_selector = activate_elevator ? go_up : dir_q;

    // Doors only while stopped with power on
    assign door_open_allowed  = door_open_btn && power_switch && stopped;
    assign door_close_allowed = door_close_btn && power_switch && stopped;

endmodule

`default_nettype wire

//--- elevator_pkg.sv
////////////////////
// Elevator floor request package
// Widths, floor and state types, stop-state check
////////////////////

`default_nettype none

package elevator_pkg;

    ////////////////////
    // Sizes
    ////////////////////

    // Floors served, numbered 0 to 10
    localparam int NUM_FLOORS = 11;
    // Bits in a floor number
    localparam int FLOOR_W    = 4;
    // Bits in the car state code
    localparam int STATE_W    = 6;
    // Codes 0..10 are stops, code n means stopped at floor n
    localparam int STOP_LAST  = 10;
    // Queue occupancy needs to reach 11
    localparam int COUNT_W    = 4;

    ////////////////////
    // Types
    ////////////////////

    // Floor number, also used as a queue slot index
    typedef logic [FLOOR_W-1:0]    floor_t;

    // Car state code from the external car FSM
    // 11..30 are moving codes, 31 is the car emergency code
    typedef logic [STATE_W-1:0]    state_t;

    // One light per floor, bit n is floor n
    typedef logic [NUM_FLOORS-1:0] lights_t;

    // True while the car is stopped at some floor
    function automatic logic is_stop_state(input state_t state);
        return state <= state_t'(STOP_LAST);
    endfunction

endpackage

`default_nettype wire

//--- floor_request.f
elevator_pkg.sv
request_if.sv
request_latch.sv
request_queue.sv
car_dispatch.sv
floor_request_top.sv
tb_floor_request.sv

//--- floor_request_top.sv
////////////////////
// Floor request controller top, joins latch, queue and dispatch
////////////////////

`timescale 1ns/100ps
`default_nettype none

module floor_request_top
    import elevator_pkg::*;
(
    input  wire        clock,
    input  wire        reset_n,
    // Hall and car buttons, bit n is floor n
    input  lights_t    floor_call_buttons,
    input  lights_t    panel_buttons,
    input  wire        door_open_btn,
    input  wire        door_close_btn,
    input  wire        emergency_btn,
    input  wire        power_switch,
    // Status from the car FSM
    input  floor_t     current_floor_state,
    input  state_t     elevator_state,
    // Commands to the car FSM
    output floor_t     elevator_floor_selector,
    output logic       direction_selector,
    output logic       activate_elevator,
    output logic       door_open_allowed,
    output logic       door_close_allowed,
    // Button lamps
    output lights_t    call_button_lights,
    output lights_t    panel_button_lights
);

    // Internal request bus
    request_if req_bus ();

    request_latch request_latch_inst (
        .clock               (clock),
        .reset_n             (reset_n),
        .floor_call_buttons  (floor_call_buttons),
        .panel_buttons       (panel_buttons),
        .current_floor_state (current_floor_state),
        .req                 (req_bus.latch),
        .call_button_lights  (call_button_lights),
        .panel_button_lights (panel_button_lights)
    );

    request_queue request_queue_inst (
        .clock   (clock),
        .reset_n (reset_n),
        .req     (req_bus.queue)
    );

    car_dispatch car_dispatch_inst (
        .clock                   (clock),
        .reset_n                 (reset_n),
        .door_open_btn           (door_open_btn),
        .door_close_btn          (door_close_btn),
        .emergency_btn           (emergency_btn),
        .power_switch            (power_switch),
        .current_floor_state     (current_floor_state),
        .elevator_state          (elevator_state),
        .req                     (req_bus.dispatch),
        .elevator_floor_selector (elevator_floor_selector),
        .direction_selector      (direction_selector),
        .activate_elevator       (activate_elevator),
        .door_open_allowed       (door_open_allowed),
        .door_close_allowed      (door_close_allowed)
    );

endmodule

`default_nettype wire

//--- request_if.sv
////////////////////
// Request bus between button latch, floor queue and car dispatch
////////////////////

`timescale 1ns/100ps
`default_nettype none

interface request_if
    import elevator_pkg::*;
();

    // Enqueue strobe and the floor that goes with it
    logic   push;
    floor_t push_floor;
    // Head removal strobe, raised on arrival
    logic   pop;
    // Level, clears queue and all lights
    logic   flush;
    // Oldest pending floor
    floor_t head_floor;
    logic   queue_empty;

    // Button side
    modport latch (
        output push, push_floor,
        input  pop, head_floor, flush
    );

    // FIFO side
    modport queue (
        output head_floor, queue_empty,
        input  push, push_floor, pop, flush
    );

    // Car side
    modport dispatch (
        output pop, flush,
        input  head_floor, queue_empty
    );

endinterface

`default_nettype wire

//--- request_latch.sv
////////////////////
// Button latch
// Accepts one press per cycle, holds call and panel lights
////////////////////

`timescale 1ns/100ps
`default_nettype none

module request_latch
    import elevator_pkg::*;
(
    input  wire        clock,
    input  wire        reset_n,
    input  lights_t    floor_call_buttons,
    input  lights_t    panel_buttons,
    input  floor_t     current_floor_state,
    request_if.latch   req,
    output lights_t    call_button_lights,
    output lights_t    panel_button_lights
);

    // Pressed, not yet lit and not the floor the car is on
    function automatic lights_t qualify(
        input lights_t buttons,
        input lights_t lit,
        input floor_t  here
    );
        lights_t q;
        for (int i = 0; i < NUM_FLOORS; i++) begin
            q[i] = buttons[i] && !lit[i] && (here != floor_t'(i));
        end
        return q;
    endfunction

    // Lowest set bit wins, scan from the top so the last hit is lowest
    function automatic floor_t lowest_floor(input lights_t req_bits);
        floor_t found;
        found = '0;
        for (int i = NUM_FLOORS - 1; i >= 0; i--) begin
            if (req_bits[i]) begin
                found = floor_t'(i);
            end
        end
        return found;
    endfunction

    ////////////////////
    // Press selection
    ////////////////////

    lights_t panel_req;
    lights_t call_req;
    logic    take_panel;
    logic    take_call;
    floor_t  pick_floor;
    logic    other_lit;

    assign panel_req  = qualify(panel_buttons, panel_button_lights, current_floor_state);
    assign call_req   = qualify(floor_call_buttons, call_button_lights, current_floor_state);

    // Panel presses have priority over hall calls
    assign take_panel = (|panel_req) && !req.flush;
    assign take_call  = !(|panel_req) && (|call_req) && !req.flush;
    assign pick_floor = (|panel_req) ? lowest_floor(panel_req) : lowest_floor(call_req);

    // Floor already queued through the other button source
    assign other_lit  = take_panel ? call_button_lights[pick_floor]
                                   : panel_button_lights[pick_floor];

    // Only a floor with both lights dark gets a queue entry
    assign req.push       = (take_panel || take_call) && !other_lit;
    assign req.push_floor = pick_floor;

    ////////////////////
    // Light registers
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else if (req.flush) begin
            call_button_lights  <= '0;
            panel_button_lights <= '0;
        end else begin
            // Served floor goes dark on both panels
            // Never the accepted floor since that one differs from the car's floor
            if (req.pop) begin
                call_button_lights[req.head_floor]  <= 1'b0;
                panel_button_lights[req.head_floor] <= 1'b0;
            end
            if (take_panel) begin
                panel_button_lights[pick_floor] <= 1'b1;
            end
            if (take_call) begin
                call_button_lights[pick_floor] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- request_queue.sv
////////////////////
// Floor request FIFO, one slot per floor, served in arrival order
////////////////////

`timescale 1ns/100ps
`default_nettype none

module request_queue
    import elevator_pkg::*;
(
    input  wire        clock,
    input  wire        reset_n,
    request_if.queue   req
);

    // Slot pointers wrap after the last floor slot
    function automatic floor_t ptr_next(input floor_t ptr);
        return (ptr == floor_t'(NUM_FLOORS - 1)) ? '0 : ptr + floor_t'(1);
    endfunction

    floor_t               fifo_mem [NUM_FLOORS];
    floor_t               rd_ptr;
    floor_t               wr_ptr;
    logic [COUNT_W-1:0]   count;
    logic                 do_push;
    logic                 do_pop;

    // Flush overrides both strobes
    assign do_push = req.push && !req.flush;
    assign do_pop  = req.pop && !req.flush;

    ////////////////////
    // Storage
    ////////////////////

    always_ff @(posedge clock) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= req.push_floor;
        end
    end

    ////////////////////
    // Pointers and occupancy
    ////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (req.flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            // Push and pop together leave the count alone
            case ({do_push, do_pop})
                2'b10:   count <= count + COUNT_W'(1);
                2'b01:   count <= count - COUNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // Oldest entry, only meaningful while not empty
    assign req.head_floor  = fifo_mem[rd_ptr];
    assign req.queue_empty = (count == '0);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the floor request testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_floor_request -f floor_request.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_floor_request)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- tb_floor_request.sv
////////////////////
// Floor request controller testbench
// Car and request models, directed tests and a random run
////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_floor_request
    import elevator_pkg::*;
();

    localparam int PERIOD          = 40;
    localparam int RESET_CYCLES    = 5;
    // Cycles the car needs per floor
    localparam int CAR_STEP        = 3;
    localparam int IDLE_LIMIT      = 150;
    localparam int RANDOM_CYCLES   = 400;
    // Three idle waits, the short directed steps and the random run, plus margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 3 * IDLE_LIMIT + RANDOM_CYCLES + 200;

    logic    clock;
    logic    reset_n;
    lights_t floor_call_buttons;
    lights_t panel_buttons;
    logic    door_open_btn;
    logic    door_close_btn;
    logic    emergency_btn;
    logic    power_switch;
    floor_t  current_floor_state;
    state_t  elevator_state;
    floor_t  elevator_floor_selector;
    logic    direction_selector;
    logic    activate_elevator;
    logic    door_open_allowed;
    logic    door_close_allowed;
    lights_t call_button_lights;
    lights_t panel_button_lights;

    // Request model, lights plus FIFO of queued floors
    lights_t m_call;
    lights_t m_panel;
    floor_t  mq[$];
    logic    m_dir;
    floor_t  head;
    logic    e_act;
    logic    e_pop;
    logic    e_dir;
    floor_t  e_sel;

    // Car model
    floor_t  car_floor;
    floor_t  car_target;
    logic    car_moving;
    int      car_timer;
    logic    act_seen;
    floor_t  sel_seen;
    floor_t  served[$];

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_start;
    int          order_ref[4] = '{2, 9, 7, 1};

    floor_request_top floor_request_top_inst (.*);

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_CYCLES * PERIOD);
        $display("Watchdog: simulation timed out after %0d cycles", WATCHDOG_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Lowest lit floor, -1 when none
    function automatic int lowest(input lights_t bits);
        for (int i = 0; i < NUM_FLOORS; i++) begin
            if (bits[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic report_fault(input string what);
        errors++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start) begin
            $display("[%s] ok", name);
        end else begin
            tests_failed++;
            $display("[%s] %0d errors", name, errors - test_start);
        end
        test_start = errors;
    endtask

    // Outputs settle by the falling edge, compare them with the model there
    task automatic sample();
        logic svc;
        logic stop;
        @(negedge clock);
        act_seen = activate_elevator;
        sel_seen = elevator_floor_selector;
        stop  = (elevator_state <= state_t'(STOP_LAST));
        head  = (mq.size() > 0) ? mq[0] : '0;
        svc   = power_switch && !emergency_btn && stop && (mq.size() > 0);
        e_act = svc && (head != current_floor_state);
        e_pop = svc && (head == current_floor_state);
        e_sel = e_act ? head : current_floor_state;
        e_dir = e_act ? (head > current_floor_state) : m_dir;
        check_value(32'(call_button_lights), 32'(m_call), "call lights");
        check_value(32'(panel_button_lights), 32'(m_panel), "panel lights");
        check_value(32'(activate_elevator), 32'(e_act), "activate");
        check_value(32'(elevator_floor_selector), 32'(e_sel), "floor selector");
        check_value(32'(direction_selector), 32'(e_dir), "direction");
        check_value(32'(door_open_allowed), 32'(door_open_btn && power_switch && stop),
                    "door open permit");
        check_value(32'(door_close_allowed), 32'(door_close_btn && power_switch && stop),
                    "door close permit");
    endtask

    // Model takes the clock edge, then the car reacts after it
    task automatic advance();
        lights_t pnl;
        lights_t cl;
        int      pick;
        floor_t  pf;
        logic    from_panel;
        if (!power_switch || emergency_btn) begin
            m_call  = '0;
            m_panel = '0;
            mq.delete();
        end else begin
            pnl = panel_buttons & ~m_panel;
            cl  = floor_call_buttons & ~m_call;
            pnl[current_floor_state] = 1'b0;
            cl[current_floor_state]  = 1'b0;
            from_panel = (pnl != '0);
            pick = from_panel ? lowest(pnl) : lowest(cl);
            pf   = floor_t'(pick);
            if (e_pop) begin
                m_call[head]  = 1'b0;
                m_panel[head] = 1'b0;
                mq.delete(0);
            end
            if (pick >= 0) begin
                // Queue entry only when the other source was dark
                if (from_panel ? !m_call[pf] : !m_panel[pf]) begin
                    mq.push_back(pf);
                end
                if (from_panel) begin
                    m_panel[pf] = 1'b1;
                end else begin
                    m_call[pf] = 1'b1;
                end
            end
        end
        if (e_act) begin
            m_dir = e_dir;
        end
        @(posedge clock);
        #2;
        move_car();
    endtask

    // Car leaves on activate, one floor per CAR_STEP cycles
    task automatic move_car();
        if (car_moving) begin
            car_timer--;
            if (car_timer == 0) begin
                car_timer = CAR_STEP;
                car_floor = (car_target > car_floor) ? car_floor + floor_t'(1)
                                                     : car_floor - floor_t'(1);
                car_moving = (car_floor != car_target);
            end
        end else if (act_seen) begin
            car_moving = 1'b1;
            car_target = sel_seen;
            car_timer  = CAR_STEP;
            served.push_back(sel_seen);
        end
        current_floor_state = car_floor;
        elevator_state = car_moving ? state_t'(STOP_LAST + 1) + state_t'(car_floor)
                                    : state_t'(car_floor);
    endtask

    task automatic cycle();
        sample();
        advance();
    endtask

    task automatic run_until_idle();
        int n;
        n = 0;
        while ((mq.size() > 0 || car_moving) && n < IDLE_LIMIT) begin
            cycle();
            n++;
        end
        if (n == IDLE_LIMIT) begin
            report_fault("car did not finish its requests in time");
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        int em_left;
        int n0;
        reset_n = 1'b0;
        floor_call_buttons = '0;
        panel_buttons = '0;
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        emergency_btn = 1'b0;
        power_switch = 1'b1;
        current_floor_state = '0;
        elevator_state = '0;
        m_call = '0;
        m_panel = '0;
        m_dir = 1'b0;
        car_floor = '0;
        car_target = '0;
        car_moving = 1'b0;
        car_timer = 0;
        rng = 32'd23;
        errors = 0;
        checks = 0;
        tests_run = 0;
        tests_failed = 0;
        test_start = 0;
        em_left = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset_n = 1'b1;

        // One panel press, car at floor 0
        panel_buttons = lights_t'(1) << 5;
        sample();
        check_value(32'(activate_elevator), 32'd0, "activate before the press is latched");
        advance();
        panel_buttons = '0;
        sample();
        check_value(32'(panel_button_lights[5]), 32'd1, "panel light of floor 5");
        check_value(32'(activate_elevator), 32'd1, "activate toward floor 5");
        check_value(32'(elevator_floor_selector), 32'd5, "selector toward floor 5");
        check_value(32'(direction_selector), 32'd1, "direction toward floor 5");
        advance();
        run_until_idle();
        finish_test("single request");

        // Requests made while the car travels 5 to 2
        served.delete();
        panel_buttons = lights_t'(1) << 2;
        cycle();
        panel_buttons = '0;
        cycle();
        floor_call_buttons = lights_t'(1) << 9;
        cycle();
        floor_call_buttons = '0;
        panel_buttons = lights_t'(1) << 7;
        cycle();
        panel_buttons = '0;
        floor_call_buttons = lights_t'(1) << 1;
        cycle();
        floor_call_buttons = '0;
        run_until_idle();
        check_value(32'(served.size()), 32'd4, "number of dispatches");
        for (int i = 0; i < served.size() && i < 4; i++) begin
            check_value(32'(served[i]), 32'(order_ref[i]), "dispatch order");
        end
        finish_test("arrival order");

        // Car at floor 1, own floor ignored
        // Floor 3 pressed again from the hall once floor 6 is queued behind it
        n0 = served.size();
        panel_buttons = lights_t'(1) << 1;
        cycle();
        panel_buttons = lights_t'(1) << 3;
        sample();
        check_value(32'(panel_button_lights[1]), 32'd0, "panel light of the car's floor");
        check_value(32'(activate_elevator), 32'd0, "activate for the car's floor");
        advance();
        panel_buttons = lights_t'(1) << 6;
        cycle();
        panel_buttons = '0;
        floor_call_buttons = lights_t'(1) << 3;
        cycle();
        floor_call_buttons = '0;
        sample();
        check_value(32'(call_button_lights[3]), 32'd1, "call light of floor 3");
        check_value(32'(panel_button_lights[3]), 32'd1, "panel light of floor 3");
        advance();
        run_until_idle();
        // A second entry for floor 3 would send the car back down here
        cycle();
        check_value(32'(served.size()), 32'(n0 + 2), "dispatches for floors 3 and 6");
        if (served.size() >= n0 + 2) begin
            check_value(32'(served[n0]), 32'd3, "first dispatch of the doubled floor");
            check_value(32'(served[n0 + 1]), 32'd6, "dispatch after the doubled floor");
        end
        finish_test("ignored presses");

        // Emergency first, then power off, car waits at floor 6
        for (int k = 0; k < 2; k++) begin
            panel_buttons = lights_t'(1) << 3;
            floor_call_buttons = lights_t'(1) << 8;
            cycle();
            if (k == 0) begin
                emergency_btn = 1'b1;
            end else begin
                power_switch = 1'b0;
            end
            sample();
            check_value(32'(activate_elevator), 32'd0, "activate during flush");
            advance();
            panel_buttons = '0;
            floor_call_buttons = '0;
            sample();
            check_value(32'(call_button_lights | panel_button_lights), 32'd0,
                        "lights after flush");
            check_value(32'(elevator_floor_selector), 32'd6, "selector after flush");
            advance();
            emergency_btn = 1'b0;
            power_switch = 1'b1;
        end
        cycle();
        finish_test("flush");

        // Permits need a stop state and power
        door_open_btn = 1'b1;
        door_close_btn = 1'b1;
        sample();
        check_value(32'({door_open_allowed, door_close_allowed}), 32'd3, "permits when stopped");
        advance();
        power_switch = 1'b0;
        cycle();
        power_switch = 1'b1;
        elevator_state = state_t'(15);
        sample();
        check_value(32'({door_open_allowed, door_close_allowed}), 32'd0, "permits when moving");
        advance();
        elevator_state = state_t'(31);
        cycle();
        door_open_btn = 1'b0;
        door_close_btn = 1'b0;
        cycle();
        finish_test("door permits");

        // Random presses with short emergencies, checked every cycle
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rng = xorshift(rng);
            panel_buttons = (rng[2:0] == 3'd0) ?
                            lights_t'(1) << (int'(rng[7:4]) % NUM_FLOORS) : '0;
            floor_call_buttons = (rng[10:8] == 3'd0) ?
                                 lights_t'(1) << (int'(rng[15:12]) % NUM_FLOORS) : '0;
            door_open_btn = rng[16];
            door_close_btn = rng[17];
            if (em_left > 0) begin
                em_left--;
            end else if (rng[25:20] == 6'd0) begin
                em_left = 3;
            end
            emergency_btn = (em_left > 0);
            cycle();
        end
        finish_test("random run");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
